// ==== filelist.f ====
rtl/fetch_pkg.sv
rtl/insn_predecode.sv
rtl/icache_spr_regs.sv
rtl/mini_icache.sv
rtl/fetch_pc_ctrl.sv
rtl/fetch_unit_top.sv
verification/tb_clock_gen.sv
verification/fetch_assertions.sv
verification/fetch_tb.sv

// ==== rtl/fetch_pc_ctrl.sv ====
//////////////////////////////////////////////////
// fetch PC and request control
// steps the PC, drives the bus request and
// registers each accepted word out to decode
//////////////////////////////////////////////////

`timescale 1ns/1ns

module fetch_pc_ctrl (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             padv_i,
   input  logic                             word_ready_i,
   input  fetch_pkg::insn_t                 new_insn_i,
   input  logic                             ack_i,
   input  logic                             err_i,
   input  logic                             hit_i,
   input  logic                             early_valid_i,
   input  logic [fetch_pkg::ADDR_WIDTH-1:0] early_pc_i,
   input  logic                             will_branch_i,
   input  logic                             to_self_i,
   input  logic                             no_rf_read_i,
   input  logic                             redirect_i,
   input  logic [fetch_pkg::ADDR_WIDTH-1:0] redirect_pc_i,
   output logic [fetch_pkg::ADDR_WIDTH-1:0] pc_o,
   output logic                             req_o,
   output logic                             fill_o,
   output logic                             block_o,
   output fetch_pkg::insn_t                 decode_insn_o,
   output logic [fetch_pkg::ADDR_WIDTH-1:0] fetched_pc_o,
   output logic                             rf_re_o,
   output logic                             ibus_err_o,
   output logic                             sleep_o
);

   logic [fetch_pkg::ADDR_WIDTH-1:0] pc_q;
   logic [fetch_pkg::ADDR_WIDTH-1:0] pc_plus4;
   logic [fetch_pkg::ADDR_WIDTH-1:0] pc_next;
   logic fetch_req_q;
   logic complete_req_q;
   logic padv_q;
   logic took_branch_q;
   logic sleep_q;
   logic bus_err_q;
   logic halted;
   logic accept;
   logic padv_fall;

   // parked on a jump-to-self or a bus error, only a redirect gets out
   assign halted = sleep_q | bus_err_q;

   // a word moves on to decode this cycle
   assign accept = word_ready_i & padv_i & !redirect_i & !halted;

   assign pc_plus4 = pc_q + 32'd4;
   assign pc_next  = early_valid_i ? early_pc_i : pc_plus4;

   // pipeline stalled under a live request, not because of our own branch
   assign padv_fall = padv_q & !padv_i & fetch_req_q & !took_branch_q;

   // a hit serves the word itself so the bus stays idle
   // complete_req_q keeps an issued request up until it is answered
   assign req_o = ((fetch_req_q & !hit_i) | complete_req_q) & !redirect_i;

   always_ff @(posedge clk)
   begin
      if (rst)
         pc_q <= fetch_pkg::RESET_PC;
      else if (redirect_i)
         pc_q <= redirect_pc_i;
      else if (accept)
         pc_q <= pc_next;
   end

   // fetched PC only follows accepted words
   always_ff @(posedge clk)
   begin
      if (rst)
         fetched_pc_o <= fetch_pkg::RESET_PC;
      else if (accept)
         fetched_pc_o <= pc_q;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         fetch_req_q <= 1'b1;
      else if (redirect_i)
         fetch_req_q <= 1'b1;
      else if (err_i | halted)
         fetch_req_q <= 1'b0;
      else if (accept & will_branch_i)
         // one dead cycle while the target settles into the PC
         fetch_req_q <= 1'b0;
      else if (padv_fall)
         fetch_req_q <= 1'b0;
      else
         fetch_req_q <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         complete_req_q <= 1'b0;
      else if (redirect_i | ack_i | err_i)
         complete_req_q <= 1'b0;
      else if (padv_fall & req_o)
         // outstanding request, hold it until ack or err
         complete_req_q <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         padv_q        <= 1'b0;
         took_branch_q <= 1'b0;
      end
      else
      begin
         padv_q        <= padv_i;
         took_branch_q <= accept & will_branch_i;
      end
   end

   // sleep and bus error both hold until a redirect
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         sleep_q   <= 1'b0;
         bus_err_q <= 1'b0;
      end
      else if (redirect_i)
      begin
         sleep_q   <= 1'b0;
         bus_err_q <= 1'b0;
      end
      else
      begin
         if (accept & to_self_i)
            sleep_q <= 1'b1;
         if (err_i)
            bus_err_q <= 1'b1;
      end
   end

   // decode output, bubble whenever the pipe moves without a new word
   always_ff @(posedge clk)
   begin
      if (rst)
         decode_insn_o <= fetch_pkg::NOP_INSN;
      else if (accept)
         decode_insn_o <= new_insn_i;
      else if (padv_i | sleep_q)
         decode_insn_o <= fetch_pkg::NOP_INSN;
   end

   // register file read goes with the accepted word, not for jumps
   assign rf_re_o = accept & !no_rf_read_i;

   // never cache a jump-to-self, it would hit forever after a redirect back
   assign fill_o = ack_i & !err_i & !to_self_i;

   assign block_o = took_branch_q | redirect_i;

   assign pc_o       = pc_q;
   assign ibus_err_o = bus_err_q;
   assign sleep_o    = sleep_q;

endmodule

// ==== rtl/fetch_pkg.sv ====
//////////////////////////////////////////////////
// fetch stage shared definitions
// widths, opcodes, cache geometry, SPR map and
// the two-view instruction word
//////////////////////////////////////////////////

package fetch_pkg;

   // datapath widths
   localparam int ADDR_WIDTH    = 32;
   localparam int INSN_WIDTH    = 32;
   localparam int RF_ADDR_WIDTH = 5;
   localparam int OPCODE_WIDTH  = 6;

   // SPR bus widths
   localparam int SPR_ADDR_WIDTH = 16;
   localparam int SPR_DATA_WIDTH = 32;

   // mini cache geometry, one word per line
   localparam int CACHE_INDEX_WIDTH = 3;
   localparam int CACHE_WORDS       = 8;
   // byte offset is two bits, tag is whatever is left
   localparam int CACHE_TAG_WIDTH   = ADDR_WIDTH - CACHE_INDEX_WIDTH - 2;

   // first fetch address out of reset
   localparam logic [ADDR_WIDTH-1:0] RESET_PC = 32'h0000_0100;

   // major opcodes the predecoder cares about
   localparam logic [OPCODE_WIDTH-1:0] OPC_J   = 6'h00;
   localparam logic [OPCODE_WIDTH-1:0] OPC_JAL = 6'h01;
   localparam logic [OPCODE_WIDTH-1:0] OPC_BNF = 6'h03;
   localparam logic [OPCODE_WIDTH-1:0] OPC_BF  = 6'h04;
   localparam logic [OPCODE_WIDTH-1:0] OPC_NOP = 6'h05;

   // instruction cache SPRs, group 4
   // bit 0 of ICCR is the cache enable
   localparam logic [SPR_ADDR_WIDTH-1:0] SPR_ICCR_ADDR  = 16'h2000;
   localparam logic [SPR_ADDR_WIDTH-1:0] SPR_ICBIR_ADDR = 16'h2002;

   // one instruction word seen as jump format or as register format
   typedef union packed {
      struct packed {
         logic [OPCODE_WIDTH-1:0]           opcode;
         logic [25:0]                       imm;
      } j;
      struct packed {
         logic [OPCODE_WIDTH-1:0]           opcode;
         logic [RF_ADDR_WIDTH-1:0]          rd;
         logic [RF_ADDR_WIDTH-1:0]          ra;
         logic [RF_ADDR_WIDTH-1:0]          rb;
         logic [10:0]                       rest;
      } r;
   } insn_t;

   // bubble word handed to decode when nothing advances
   localparam insn_t NOP_INSN = {OPC_NOP, {(INSN_WIDTH-OPCODE_WIDTH){1'b0}}};

endpackage

// ==== rtl/fetch_unit_top.sv ====
//////////////////////////////////////////////////
// instruction fetch unit top level
// PC control, predecode, mini cache and the
// cache SPR registers
//////////////////////////////////////////////////

`timescale 1ns/1ns

module fetch_unit_top (
   input  logic                                 clk,
   input  logic                                 rst,
   // instruction bus
   output logic [fetch_pkg::ADDR_WIDTH-1:0]     ibus_adr_o,
   output logic                                 ibus_req_o,
   input  logic                                 ibus_ack_i,
   input  logic                                 ibus_err_i,
   input  fetch_pkg::insn_t                     ibus_dat_i,
   // pipeline control
   input  logic                                 padv_i,
   input  logic                                 flag_i,
   input  logic                                 redirect_i,
   input  logic [fetch_pkg::ADDR_WIDTH-1:0]     redirect_pc_i,
   // SPR bus
   input  logic [fetch_pkg::SPR_ADDR_WIDTH-1:0] spr_addr_i,
   input  logic                                 spr_we_i,
   input  logic                                 spr_stb_i,
   input  logic [fetch_pkg::SPR_DATA_WIDTH-1:0] spr_dat_i,
   output logic [fetch_pkg::SPR_DATA_WIDTH-1:0] spr_dat_o,
   output logic                                 spr_ack_o,
   // to decode and register file
   output fetch_pkg::insn_t                     decode_insn_o,
   output logic [fetch_pkg::ADDR_WIDTH-1:0]     fetched_pc_o,
   output logic [fetch_pkg::RF_ADDR_WIDTH-1:0]  rfa_adr_o,
   output logic [fetch_pkg::RF_ADDR_WIDTH-1:0]  rfb_adr_o,
   output logic                                 rf_re_o,
   output logic                                 ibus_err_o,
   output logic                                 sleep_o
);

   logic [fetch_pkg::ADDR_WIDTH-1:0] pc;
   logic [fetch_pkg::ADDR_WIDTH-1:0] early_pc;
   fetch_pkg::insn_t cache_insn;
   fetch_pkg::insn_t new_insn;
   logic cache_hit;
   logic word_ready;
   logic early_valid;
   logic will_branch;
   logic to_self;
   logic no_rf_read;
   logic cache_en;
   logic invalidate;
   logic fill;
   logic block;

   // cached word wins, it arrives with zero latency
   assign new_insn   = cache_hit ? cache_insn : ibus_dat_i;
   assign word_ready = cache_hit | ibus_ack_i;

   fetch_pc_ctrl u_pc_ctrl (
      .clk           (clk),
      .rst           (rst),
      .padv_i        (padv_i),
      .word_ready_i  (word_ready),
      .new_insn_i    (new_insn),
      .ack_i         (ibus_ack_i),
      .err_i         (ibus_err_i),
      .hit_i         (cache_hit),
      .early_valid_i (early_valid),
      .early_pc_i    (early_pc),
      .will_branch_i (will_branch),
      .to_self_i     (to_self),
      .no_rf_read_i  (no_rf_read),
      .redirect_i    (redirect_i),
      .redirect_pc_i (redirect_pc_i),
      .pc_o          (pc),
      .req_o         (ibus_req_o),
      .fill_o        (fill),
      .block_o       (block),
      .decode_insn_o (decode_insn_o),
      .fetched_pc_o  (fetched_pc_o),
      .rf_re_o       (rf_re_o),
      .ibus_err_o    (ibus_err_o),
      .sleep_o       (sleep_o)
   );

   // bus address is the live PC
   assign ibus_adr_o = pc;

   insn_predecode u_predecode (
      .pc_i          (pc),
      .insn_i        (new_insn),
      .ready_i       (word_ready),
      .flag_i        (flag_i),
      .early_valid_o (early_valid),
      .early_pc_o    (early_pc),
      .will_branch_o (will_branch),
      .to_self_o     (to_self),
      .rfa_adr_o     (rfa_adr_o),
      .rfb_adr_o     (rfb_adr_o),
      .no_rf_read_o  (no_rf_read)
   );

   mini_icache u_icache (
      .clk          (clk),
      .rst          (rst),
      .pc_i         (pc),
      .cache_en_i   (cache_en),
      .invalidate_i (invalidate),
      .fill_i       (fill),
      .fill_insn_i  (ibus_dat_i),
      .block_i      (block),
      .hit_o        (cache_hit),
      .hit_insn_o   (cache_insn)
   );

   icache_spr_regs u_spr_regs (
      .clk          (clk),
      .rst          (rst),
      .spr_addr_i   (spr_addr_i),
      .spr_we_i     (spr_we_i),
      .spr_stb_i    (spr_stb_i),
      .spr_dat_i    (spr_dat_i),
      .spr_dat_o    (spr_dat_o),
      .spr_ack_o    (spr_ack_o),
      .cache_en_o   (cache_en),
      .invalidate_o (invalidate)
   );

endmodule

// ==== rtl/icache_spr_regs.sv ====
//////////////////////////////////////////////////
// instruction cache SPR block
// holds the enable bit and raises the
// block-invalidate pulse
//////////////////////////////////////////////////

`timescale 1ns/1ns

module icache_spr_regs (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic [fetch_pkg::SPR_ADDR_WIDTH-1:0] spr_addr_i,
   input  logic                                 spr_we_i,
   input  logic                                 spr_stb_i,
   input  logic [fetch_pkg::SPR_DATA_WIDTH-1:0] spr_dat_i,
   output logic [fetch_pkg::SPR_DATA_WIDTH-1:0] spr_dat_o,
   output logic                                 spr_ack_o,
   output logic                                 cache_en_o,
   output logic                                 invalidate_o
);

   logic iccr_sel;
   logic icbir_sel;

   assign iccr_sel  = spr_stb_i & (spr_addr_i == fetch_pkg::SPR_ICCR_ADDR);
   assign icbir_sel = spr_stb_i & (spr_addr_i == fetch_pkg::SPR_ICBIR_ADDR);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         cache_en_o   <= 1'b0;
         invalidate_o <= 1'b0;
      end
      else
      begin
         // enable lives in bit 0 of ICCR
         if (iccr_sel & spr_we_i)
            cache_en_o <= spr_dat_i[0];
         // any ICBIR write flushes the whole mini cache, data ignored
         invalidate_o <= icbir_sel & spr_we_i;
      end
   end

   // only ICCR reads back, the rest reads zero
   assign spr_dat_o = iccr_sel ? {{(fetch_pkg::SPR_DATA_WIDTH-1){1'b0}}, cache_en_o} : '0;

   // single cycle access
   assign spr_ack_o = 1'b1;

endmodule

// ==== rtl/insn_predecode.sv ====
//////////////////////////////////////////////////
// instruction predecoder
// finds early branch targets, jump-to-self and
// register file read addresses in the new word
//////////////////////////////////////////////////

`timescale 1ns/1ns

module insn_predecode (
   input  logic [fetch_pkg::ADDR_WIDTH-1:0]    pc_i,
   input  fetch_pkg::insn_t                    insn_i,
   input  logic                                ready_i,
   input  logic                                flag_i,
   output logic                                early_valid_o,
   output logic [fetch_pkg::ADDR_WIDTH-1:0]    early_pc_o,
   output logic                                will_branch_o,
   output logic                                to_self_o,
   output logic [fetch_pkg::RF_ADDR_WIDTH-1:0] rfa_adr_o,
   output logic [fetch_pkg::RF_ADDR_WIDTH-1:0] rfb_adr_o,
   output logic                                no_rf_read_o
);

   logic [fetch_pkg::ADDR_WIDTH-1:0] target;

   // word offset, sign extended and turned into a byte offset
   assign target = pc_i + {{(fetch_pkg::ADDR_WIDTH-28){insn_i.j.imm[25]}},
                           insn_i.j.imm, 2'b00};

   assign early_pc_o = target;

   always_comb
   begin
      early_valid_o = 1'b0;
      will_branch_o = 1'b0;
      no_rf_read_o  = 1'b0;
      // nothing is decoded unless a word is really arriving
      if (ready_i)
      begin
         case (insn_i.j.opcode)
            fetch_pkg::OPC_J,
            fetch_pkg::OPC_JAL:
            begin
               early_valid_o = 1'b1;
               will_branch_o = 1'b1;
               no_rf_read_o  = 1'b1;
            end
            // conditional branches resolve on the current flag
            fetch_pkg::OPC_BNF:
            begin
               early_valid_o = !flag_i;
               will_branch_o = !flag_i;
               no_rf_read_o  = 1'b1;
            end
            fetch_pkg::OPC_BF:
            begin
               early_valid_o = flag_i;
               will_branch_o = flag_i;
               no_rf_read_o  = 1'b1;
            end
            default:
            begin
               early_valid_o = 1'b0;
               will_branch_o = 1'b0;
               no_rf_read_o  = 1'b0;
            end
         endcase
      end
   end

   // branch onto itself, the core parks here
   assign to_self_o = early_valid_o & (target == pc_i);

   // operand addresses straight from the register view
   assign rfa_adr_o = ready_i ? insn_i.r.ra : '0;
   assign rfb_adr_o = ready_i ? insn_i.r.rb : '0;

endmodule

// ==== rtl/mini_icache.sv ====
//////////////////////////////////////////////////
// mini instruction cache
// eight words, direct mapped, one word per line
// filled from the bus as words are acked
//////////////////////////////////////////////////

`timescale 1ns/1ns

module mini_icache (
   input  logic                             clk,
   input  logic                             rst,
   input  logic [fetch_pkg::ADDR_WIDTH-1:0] pc_i,
   input  logic                             cache_en_i,
   input  logic                             invalidate_i,
   input  logic                             fill_i,
   input  fetch_pkg::insn_t                 fill_insn_i,
   input  logic                             block_i,
   output logic                             hit_o,
   output fetch_pkg::insn_t                 hit_insn_o
);

   // storage
   logic [fetch_pkg::CACHE_WORDS-1:0]     valid_q;
   logic [fetch_pkg::CACHE_TAG_WIDTH-1:0] tag_mem [fetch_pkg::CACHE_WORDS];
   fetch_pkg::insn_t                      data_mem [fetch_pkg::CACHE_WORDS];

   // address split
   logic [fetch_pkg::CACHE_INDEX_WIDTH-1:0] index;
   logic [fetch_pkg::CACHE_TAG_WIDTH-1:0]   pc_tag;
   logic                                    tag_match;

   // word index is pc[4:2], byte offset is dropped
   assign index  = pc_i[fetch_pkg::CACHE_INDEX_WIDTH+1:2];
   assign pc_tag = pc_i[fetch_pkg::ADDR_WIDTH-1:fetch_pkg::CACHE_INDEX_WIDTH+2];

   assign tag_match = valid_q[index] & (tag_mem[index] == pc_tag);

   // no hit in the cycle after a taken branch or during a redirect
   assign hit_o = cache_en_i & !block_i & tag_match;

   assign hit_insn_o = data_mem[index];

   // valid bits are control state
   always_ff @(posedge clk)
   begin
      if (rst)
         valid_q <= '0;
      else if (invalidate_i | !cache_en_i)
         // flush on ICBIR write, and keep flushed while disabled
         valid_q <= '0;
      else if (fill_i)
         valid_q[index] <= 1'b1;
   end

   // tag and data arrays carry no reset
   always_ff @(posedge clk)
   begin
      if (fill_i)
      begin
         tag_mem[index]  <= pc_tag;
         data_mem[index] <= fill_insn_i;
      end
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and judge the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f filelist.f \
   -o Vfetch_tb > build.log 2>&1 \
   && ./obj_dir/Vfetch_tb > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0

// ==== verification/fetch_assertions.sv ====
//////////////////////////////////////////////////
// fetch unit bus and pipeline properties
// bound into the fetch top level
//////////////////////////////////////////////////

`timescale 1ns/1ns

module fetch_assertions (
   input logic                                clk,
   input logic                                rst,
   input logic                                ibus_req_i,
   input logic                                ibus_ack_i,
   input logic                                ibus_err_i,
   input logic [fetch_pkg::ADDR_WIDTH-1:0]    ibus_adr_i,
   input logic                                sleep_i,
   input logic                                rf_re_i,
   input logic [fetch_pkg::RF_ADDR_WIDTH-1:0] rfa_adr_i,
   input logic [fetch_pkg::RF_ADDR_WIDTH-1:0] rfb_adr_i,
   input logic [fetch_pkg::ADDR_WIDTH-1:0]    fetched_pc_i,
   input fetch_pkg::insn_t                    decode_insn_i
);

   // open request keeps its address until answered
   adr_stable: assert property (@(posedge clk) disable iff (rst)
      (ibus_req_i && !ibus_ack_i && !ibus_err_i) |=> (ibus_adr_i == $past(ibus_adr_i)))
      else $error("bus address moved under an open request");

   // parked core stays off the bus
   no_req_asleep: assert property (@(posedge clk) disable iff (rst)
      sleep_i |-> !ibus_req_i)
      else $error("request raised while asleep");

   // register read only with a word really moving to decode
   // that word and its address show up at decode one cycle later
   rf_read_accept: assert property (@(posedge clk) disable iff (rst)
      rf_re_i |=> ((fetched_pc_i == $past(ibus_adr_i)) &&
                   (decode_insn_i.r.ra == $past(rfa_adr_i)) &&
                   (decode_insn_i.r.rb == $past(rfb_adr_i))))
      else $error("register read without an accepted word");

endmodule

bind fetch_unit_top fetch_assertions u_fetch_assertions (
   .clk           (clk),
   .rst           (rst),
   .ibus_req_i    (ibus_req_o),
   .ibus_ack_i    (ibus_ack_i),
   .ibus_err_i    (ibus_err_i),
   .ibus_adr_i    (ibus_adr_o),
   .sleep_i       (sleep_o),
   .rf_re_i       (rf_re_o),
   .rfa_adr_i     (rfa_adr_o),
   .rfb_adr_i     (rfb_adr_o),
   .fetched_pc_i  (fetched_pc_o),
   .decode_insn_i (decode_insn_o)
);

// ==== verification/fetch_tb.sv ====
//////////////////////////////////////////////////
// fetch unit testbench
// bus memory model, program, reference next-PC
// model and word-by-word compare against decode
//////////////////////////////////////////////////

`timescale 1ns/1ns

module fetch_tb;

   logic clk;
   logic rst;
   logic [fetch_pkg::ADDR_WIDTH-1:0] ibus_adr_o;
   logic ibus_req_o;
   logic ibus_ack_i;
   logic ibus_err_i;
   fetch_pkg::insn_t ibus_dat_i;
   logic padv_i;
   logic flag_i;
   logic redirect_i;
   logic [fetch_pkg::ADDR_WIDTH-1:0] redirect_pc_i;
   logic [fetch_pkg::SPR_ADDR_WIDTH-1:0] spr_addr_i;
   logic spr_we_i;
   logic spr_stb_i;
   logic [fetch_pkg::SPR_DATA_WIDTH-1:0] spr_dat_i;
   logic [fetch_pkg::SPR_DATA_WIDTH-1:0] spr_dat_o;
   logic spr_ack_o;
   fetch_pkg::insn_t decode_insn_o;
   logic [fetch_pkg::ADDR_WIDTH-1:0] fetched_pc_o;
   logic [fetch_pkg::RF_ADDR_WIDTH-1:0] rfa_adr_o;
   logic [fetch_pkg::RF_ADDR_WIDTH-1:0] rfb_adr_o;
   logic rf_re_o;
   logic ibus_err_o;
   logic sleep_o;

   // memory model state, 4 KB aliased program space
   logic [31:0] mem [1024];
   logic resp;
   logic busy;
   logic done;
   int waited;
   int delay;
   logic [fetch_pkg::ADDR_WIDTH-1:0] err_adr;
   logic padv_rand;

   // compare process state
   int accepted;
   int req_cycles;
   logic took;
   fetch_pkg::insn_t exp_word;
   logic [fetch_pkg::ADDR_WIDTH-1:0] exp_pc;
   logic [fetch_pkg::ADDR_WIDTH-1:0] seen_pc;
   logic seen_flag;
   int base;
   int snap;

   tb_clock_gen clk_gen (.clk_o(clk), .rst_o(rst));

   fetch_unit_top dut_i (.*);

   // answers only while the request is high, err at one chosen address
   assign ibus_dat_i = mem[ibus_adr_o[11:2]];
   assign ibus_ack_i = resp & ibus_req_o & (ibus_adr_o != err_adr);
   assign ibus_err_i = resp & ibus_req_o & (ibus_adr_o == err_adr);

   task automatic fail_run;
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_insn(input string name, input fetch_pkg::insn_t exp,
                             input fetch_pkg::insn_t act);
      if (act !== exp)
      begin
         $display("FAIL %s expected %h actual %h", name, exp, act);
         fail_run();
      end
   endtask

   task automatic check_pc(input string name, input logic [fetch_pkg::ADDR_WIDTH-1:0] exp,
                           input logic [fetch_pkg::ADDR_WIDTH-1:0] act);
      if (act !== exp)
      begin
         $display("FAIL %s expected %h actual %h", name, exp, act);
         fail_run();
      end
   endtask

   task automatic check_rf(input string name, input logic [fetch_pkg::RF_ADDR_WIDTH-1:0] exp,
                           input logic [fetch_pkg::RF_ADDR_WIDTH-1:0] act);
      if (act !== exp)
      begin
         $display("FAIL %s expected %h actual %h", name, exp, act);
         fail_run();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("FAIL %s expected %b actual %b", name, exp, act);
         fail_run();
      end
   endtask

   // the four early-branch opcodes, none of them reads the register file
   function automatic logic is_jump(input fetch_pkg::insn_t w);
      return (w.j.opcode == fetch_pkg::OPC_J) || (w.j.opcode == fetch_pkg::OPC_JAL) ||
             (w.j.opcode == fetch_pkg::OPC_BF) || (w.j.opcode == fetch_pkg::OPC_BNF);
   endfunction

   // next PC: taken jump goes to pc plus word offset, anything else steps by 4
   function automatic logic [fetch_pkg::ADDR_WIDTH-1:0] ref_next_pc(
      input logic [fetch_pkg::ADDR_WIDTH-1:0] pc, input fetch_pkg::insn_t w, input logic flag);
      logic [fetch_pkg::ADDR_WIDTH-1:0] target;
      logic taken;
      target = pc + {{6{w.j.imm[25]}}, w.j.imm} * 4;
      taken = (w.j.opcode == fetch_pkg::OPC_J) || (w.j.opcode == fetch_pkg::OPC_JAL) ||
              ((w.j.opcode == fetch_pkg::OPC_BF) && flag) ||
              ((w.j.opcode == fetch_pkg::OPC_BNF) && !flag);
      return taken ? target : pc + 32'd4;
   endfunction

   task automatic put_word(input logic [31:0] adr, input logic [5:0] op, input logic [25:0] imm);
      mem[adr[11:2]] = {op, imm};
   endtask

   task automatic load_program;
      // plain ALU-style words carrying their own address
      for (int i = 0; i < 1024; i++)
         mem[i] = {6'h27, 26'(i * 4)};
      put_word(32'h120, fetch_pkg::OPC_BF, 26'd2);
      put_word(32'h128, fetch_pkg::OPC_BNF, 26'd2);
      put_word(32'h130, fetch_pkg::OPC_J, 26'd4);
      put_word(32'h140, fetch_pkg::OPC_JAL, 26'd2);
      // jump-to-self parks the core
      put_word(32'h148, fetch_pkg::OPC_J, 26'd0);
      // eight-word loop for the cache
      put_word(32'h21c, fetch_pkg::OPC_J, 26'h3fffff9);
   endtask

   // memory latency 1 to 3 cycles, restarted whenever the request drops
   always
   begin
      @(posedge clk);
      busy = ibus_req_o;
      done = ibus_ack_i | ibus_err_i;
      #1;
      if (rst || !busy || done)
      begin
         waited = 0;
         delay = $urandom_range(3, 1);
      end
      else
         waited = waited + 1;
      resp = !rst && (waited >= delay);
   end

   // pipeline advance toggled at random
   always
   begin
      @(posedge clk);
      #1;
      if (padv_rand)
         padv_i = ($urandom % 4) != 0;
   end

   // compare process, one check per accepted word
   always
   begin
      @(posedge clk);
      took = !rst && dut_i.word_ready && padv_i && !redirect_i && !sleep_o && !ibus_err_o;
      if (!rst && ibus_req_o)
         req_cycles = req_cycles + 1;
      if (rst)
         exp_pc = fetch_pkg::RESET_PC;
      else if (took)
      begin
         exp_word = mem[exp_pc[11:2]];
         // a word from the bus must have been fetched at the expected address
         if (ibus_ack_i)
            check_pc("bus address", exp_pc, ibus_adr_o);
         check_bit("rf read enable", !is_jump(exp_word), rf_re_o);
         if (rf_re_o)
         begin
            check_rf("rfa address", exp_word.r.ra, rfa_adr_o);
            check_rf("rfb address", exp_word.r.rb, rfb_adr_o);
         end
         seen_pc = exp_pc;
         seen_flag = flag_i;
         #1;
         check_insn("decode word", exp_word, decode_insn_o);
         check_pc("fetched pc", seen_pc, fetched_pc_o);
         exp_pc = ref_next_pc(seen_pc, exp_word, seen_flag);
         accepted = accepted + 1;
      end
      else if (padv_i)
      begin
         if (redirect_i)
            exp_pc = redirect_pc_i;
         #1;
         check_insn("bubble", fetch_pkg::NOP_INSN, decode_insn_o);
      end
      else if (redirect_i)
         exp_pc = redirect_pc_i;
   end

   task automatic wait_accepts(input int target, input int limit);
      int n;
      n = 0;
      while (accepted < target && n < limit)
      begin
         @(posedge clk);
         #2;
         n++;
      end
      if (accepted < target)
      begin
         $display("timeout waiting for words to reach decode");
         fail_run();
      end
   endtask

   task automatic wait_sleep(input int limit);
      int n;
      n = 0;
      while (!sleep_o && n < limit)
      begin
         @(posedge clk);
         #2;
         n++;
      end
      if (!sleep_o)
      begin
         $display("timeout waiting for sleep after jump-to-self");
         fail_run();
      end
   endtask

   task automatic wait_bus_err(input int limit);
      int n;
      n = 0;
      while (!ibus_err_o && n < limit)
      begin
         @(posedge clk);
         #2;
         n++;
      end
      if (!ibus_err_o)
      begin
         $display("timeout waiting for the bus error flag");
         fail_run();
      end
   endtask

   task automatic wait_reset_done(input int limit);
      int n;
      n = 0;
      while (rst && n < limit)
      begin
         @(posedge clk);
         #2;
         n++;
      end
      if (rst)
      begin
         $display("reset never released");
         fail_run();
      end
   endtask

   // parked fetch, bus must stay quiet
   task automatic requests_stay_low;
      repeat (8)
      begin
         @(posedge clk);
         check_bit("request while parked", 1'b0, ibus_req_o);
      end
   endtask

   task automatic redirect_to(input logic [fetch_pkg::ADDR_WIDTH-1:0] pc);
      @(posedge clk);
      #1;
      redirect_i = 1'b1;
      redirect_pc_i = pc;
      @(posedge clk);
      #1;
      redirect_i = 1'b0;
   endtask

   task automatic spr_write(input logic [fetch_pkg::SPR_ADDR_WIDTH-1:0] adr,
                            input logic [fetch_pkg::SPR_DATA_WIDTH-1:0] dat);
      @(posedge clk);
      #1;
      spr_addr_i = adr;
      spr_dat_i = dat;
      spr_we_i = 1'b1;
      spr_stb_i = 1'b1;
      @(posedge clk);
      #1;
      spr_we_i = 1'b0;
      spr_stb_i = 1'b0;
   endtask

   task automatic spr_check_enable(input logic exp);
      @(posedge clk);
      #1;
      spr_addr_i = fetch_pkg::SPR_ICCR_ADDR;
      spr_stb_i = 1'b1;
      @(posedge clk);
      check_bit("ICCR enable readback", exp, spr_dat_o[0]);
      check_bit("spr ack", 1'b1, spr_ack_o);
      #1;
      spr_stb_i = 1'b0;
   endtask

   initial
   begin
      void'($urandom(76));
      padv_i = 1'b0;
      flag_i = 1'b0;
      redirect_i = 1'b0;
      redirect_pc_i = '0;
      spr_addr_i = '0;
      spr_we_i = 1'b0;
      spr_stb_i = 1'b0;
      spr_dat_i = '0;
      resp = 1'b0;
      waited = 0;
      delay = 1;
      err_adr = '1;
      padv_rand = 1'b0;
      accepted = 0;
      req_cycles = 0;
      exp_pc = fetch_pkg::RESET_PC;
      load_program();
      wait_reset_done(40);
      padv_rand = 1'b1;

      // straight code, bnf taken, ends parked on the self jump
      wait_sleep(600);
      check_bit("words reached decode", 1'b1, accepted == 14);
      requests_stay_low();

      // same code with flag high, bf taken instead
      @(posedge clk);
      #1;
      flag_i = 1'b1;
      redirect_to(fetch_pkg::RESET_PC);
      wait_sleep(600);
      requests_stay_low();

      // bus error parks fetch until redirect
      err_adr = 32'h508;
      redirect_to(32'h500);
      wait_bus_err(300);
      requests_stay_low();
      err_adr = '1;
      base = accepted;
      redirect_to(32'h600);
      wait_accepts(base + 4, 300);

      // cache on, loop pass two must come from the cache
      spr_check_enable(1'b0);
      spr_write(fetch_pkg::SPR_ICCR_ADDR, 32'h1);
      spr_check_enable(1'b1);
      base = accepted;
      redirect_to(32'h200);
      wait_accepts(base + 8, 400);
      snap = req_cycles;
      wait_accepts(base + 16, 400);
      check_bit("bus idle on cached pass", 1'b1, req_cycles == snap);

      // block invalidate, bus traffic comes back
      spr_write(fetch_pkg::SPR_ICBIR_ADDR, 32'h0);
      snap = req_cycles;
      wait_accepts(base + 32, 800);
      check_bit("requests after invalidate", 1'b1, req_cycles > snap);

      $display("Simulation passed");
      $finish;
   end

endmodule

// ==== verification/tb_clock_gen.sv ====
//////////////////////////////////////////////////
// testbench clock and reset source
// 4 ns clock, reset held for 16 cycles
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_clock_gen (
   output logic clk_o,
   output logic rst_o
);

   initial
   begin
      clk_o = 1'b0;
      forever #2 clk_o = ~clk_o;
   end

   // release just after an edge like every other driven input
   initial
   begin
      rst_o = 1'b1;
      repeat (16) @(posedge clk_o);
      #1;
      rst_o = 1'b0;
   end

endmodule
